/* Makefile */
# Verilator build and run for the load/store unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
src/rv32_lsu_pkg.sv
src/lsu_req_if.sv
src/mem_access_if.sv
src/lsu_issue.sv
src/agu.sv
src/wb_master.sv
src/load_extend.sv
src/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu.sv

/* src/agu.sv */
// Address generation unit computing the effective address, byte enables, store lanes and alignment.
`timescale 1ns/1ps

module agu import rv32_lsu_pkg::*; (
  lsu_req_if.consumer     rq,
  mem_access_if.producer  acc
);

  logic [XLEN-1:0] addr;
  logic [1:0]      byte_offset;

  // The sum wraps around at 32 bits, as in the base ISA.
  assign addr        = rq.base + rq.offset;
  assign byte_offset = addr[1:0];

  assign acc.addr = addr;

  // Stores are the operations with bit 3 set.
  assign acc.we = (rq.op == SB) || (rq.op == SH) || (rq.op == SW);

  // The low bytes of the store data move up to the first enabled lane.
  // Lanes outside the select mask carry leftovers that the slave ignores.
  assign acc.wdata = rq.wdata << {byte_offset, 3'b000};

  // Byte enables and alignment.
  always_comb begin
    acc.sel        = '0;
    acc.misaligned = 1'b0;
    unique case (rq.op)
      LB, LBU, SB: begin
        // A single byte is always aligned.
        acc.sel = SEL_W'(1) << byte_offset;
      end
      LH, LHU, SH: begin
        // A half uses the lower or upper lane pair and must start on an even byte.
        acc.sel        = byte_offset[1] ? 4'b1100 : 4'b0011;
        acc.misaligned = byte_offset[0];
      end
      LW, SW: begin
        acc.sel        = '1;
        acc.misaligned = (byte_offset != 2'b00);
      end
      default: begin
        acc.sel        = '0;
        acc.misaligned = 1'b0;
      end
    endcase
  end

endmodule

/* src/load_extend.sv */
// Load data alignment that picks the addressed byte or half and extends it to a full word.
`timescale 1ns/1ps

module load_extend import rv32_lsu_pkg::*; (
  lsu_req_if.consumer     rq,
  mem_access_if.consumer  acc,
  input  logic [XLEN-1:0] rdata_raw,
  output logic [XLEN-1:0] resp_rdata
);

  logic [XLEN-1:0] shifted;
  logic [7:0]      byte_val;
  logic [15:0]     half_val;

  // Move the addressed lane down to bit 0.
  // A half is aligned here, so its offset is 0 or 2.
  assign shifted  = rdata_raw >> {acc.addr[1:0], 3'b000};
  assign byte_val = shifted[7:0];
  assign half_val = shifted[15:0];

  always_comb begin
    unique case (rq.op)
      LB:      resp_rdata = {{(XLEN - 8){byte_val[7]}}, byte_val};
      LBU:     resp_rdata = {{(XLEN - 8){1'b0}}, byte_val};
      LH:      resp_rdata = {{(XLEN - 16){half_val[15]}}, half_val};
      LHU:     resp_rdata = {{(XLEN - 16){1'b0}}, half_val};
      LW:      resp_rdata = rdata_raw;
      // Stores return no data.
      default: resp_rdata = '0;
    endcase
  end

endmodule

/* src/lsu_issue.sv */
// Request input stage that accepts one memory request and holds it until its response.
`timescale 1ns/1ps

module lsu_issue import rv32_lsu_pkg::*; (
  input  logic            CLK,
  input  logic            reset,
  input  logic            req_valid,
  input  mem_op_t         req_op,
  input  logic [XLEN-1:0] req_base,
  input  logic [XLEN-1:0] req_offset,
  input  logic [XLEN-1:0] req_wdata,
  output logic            req_ready,
  input  logic            resp_valid,
  lsu_req_if.producer     rq
);

  // Set from acceptance until the response cycle has passed.
  logic busy;
  logic accept;

  // Only one request may be in flight, so the stage is ready exactly when idle.
  assign req_ready = ~busy;
  assign accept    = req_valid & ~busy;

  // Control state.
  // The response clears busy, so the next request can be taken one cycle later.
  always_ff @(posedge CLK) begin
    if (reset) begin
      busy     <= 1'b0;
      rq.start <= 1'b0;
    end else begin
      rq.start <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (resp_valid) begin
        busy <= 1'b0;
      end
    end
  end

  // Payload registers.
  // They load only on acceptance and are otherwise held for the downstream blocks.
  always_ff @(posedge CLK) begin
    if (accept) begin
      rq.op     <= req_op;
      rq.base   <= req_base;
      rq.offset <= req_offset;
      rq.wdata  <= req_wdata;
    end
  end

endmodule

/* src/lsu_req_if.sv */
// Held memory request passed from the issue stage to address generation, bus and load paths.
`timescale 1ns/1ps

interface lsu_req_if import rv32_lsu_pkg::*; ();

  // One-cycle pulse in the cycle after a request is accepted.
  logic start;

  // Request fields. They stay stable until the response has been taken.
  mem_op_t op;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] offset;
  logic [XLEN-1:0] wdata;

  // The issue stage owns every field.
  modport producer (
    output start,
    output op,
    output base,
    output offset,
    output wdata
  );

  // Address generation, the bus master and load extension only read.
  modport consumer (
    input start,
    input op,
    input base,
    input offset,
    input wdata
  );

endinterface

/* src/lsu_top.sv */
// Load/store unit top level joining the issue stage, AGU, Wishbone master and load extension.
`timescale 1ns/1ps

module lsu_top import rv32_lsu_pkg::*; (
  input  logic             CLK,
  input  logic             reset,
  // Pipeline side.
  input  logic             req_valid,
  input  mem_op_t          req_op,
  input  logic [XLEN-1:0]  req_base,
  input  logic [XLEN-1:0]  req_offset,
  input  logic [XLEN-1:0]  req_wdata,
  output logic             req_ready,
  output logic             resp_valid,
  output logic             resp_fault,
  output logic [XLEN-1:0]  resp_rdata,
  // Wishbone classic master.
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output logic [XLEN-1:0]  wb_adr,
  output logic [SEL_W-1:0] wb_sel,
  output logic [XLEN-1:0]  wb_dat_o,
  input  logic [XLEN-1:0]  wb_dat_i,
  input  logic             wb_ack
);

  // Bus word before lane selection and extension.
  logic [XLEN-1:0] rdata_raw;

  lsu_req_if    rq_if ();
  mem_access_if acc_if ();

  lsu_issue u_issue (
    .CLK        (CLK),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_base   (req_base),
    .req_offset (req_offset),
    .req_wdata  (req_wdata),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .rq         (rq_if)
  );

  agu u_agu (
    .rq  (rq_if),
    .acc (acc_if)
  );

  wb_master u_wb_master (
    .CLK        (CLK),
    .reset      (reset),
    .rq         (rq_if),
    .acc        (acc_if),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_sel     (wb_sel),
    .wb_dat_o   (wb_dat_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .resp_valid (resp_valid),
    .resp_fault (resp_fault),
    .rdata_raw  (rdata_raw)
  );

  load_extend u_load_extend (
    .rq         (rq_if),
    .acc        (acc_if),
    .rdata_raw  (rdata_raw),
    .resp_rdata (resp_rdata)
  );

endmodule

/* src/mem_access_if.sv */
// Generated access carrying address, byte enables, lane-placed store data and the alignment flag.
`timescale 1ns/1ps

interface mem_access_if import rv32_lsu_pkg::*; ();

  // Effective byte address of the access.
  logic [XLEN-1:0] addr;

  // Byte lanes touched by the access.
  logic [SEL_W-1:0] sel;

  // Store data already moved onto the enabled lanes.
  logic [XLEN-1:0] wdata;

  // High for store operations.
  logic we;

  // High when the access crosses its natural alignment.
  logic misaligned;

  modport producer (
    output addr,
    output sel,
    output wdata,
    output we,
    output misaligned
  );

  modport consumer (
    input addr,
    input sel,
    input wdata,
    input we,
    input misaligned
  );

endinterface

/* src/rv32_lsu_pkg.sv */
// Load/store unit package holding the memory operation codes, the bus FSM states and the widths.
package rv32_lsu_pkg;

  // Width of the data path and of every address.
  localparam int XLEN = 32;

  // One byte enable per byte lane of the data path.
  localparam int SEL_W = XLEN / 8;

  // Memory operations issued by the pipeline.
  // Bit 3 marks a store and bit 2 marks an unsigned load.
  // The two low bits give the access size (0 byte, 1 half, 2 word).
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LBU = 4'b0100,
    LHU = 4'b0101,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } mem_op_t;

  // States of the Wishbone master.
  // WB_IDLE waits for a start pulse from the issue stage.
  // WB_BUS holds the classic cycle open until the slave acks.
  // WB_RESP presents the response to the pipeline for one cycle.
  typedef enum logic [1:0] {
    WB_IDLE = 2'b00,
    WB_BUS  = 2'b01,
    WB_RESP = 2'b10
  } wb_state_t;

endpackage

/* src/wb_master.sv */
// Wishbone classic master FSM that runs one bus cycle per request or answers a fault directly.
`timescale 1ns/1ps

module wb_master import rv32_lsu_pkg::*; (
  input  logic             CLK,
  input  logic             reset,
  lsu_req_if.consumer      rq,
  mem_access_if.consumer   acc,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output logic [XLEN-1:0]  wb_adr,
  output logic [SEL_W-1:0] wb_sel,
  output logic [XLEN-1:0]  wb_dat_o,
  input  logic [XLEN-1:0]  wb_dat_i,
  input  logic             wb_ack,
  output logic             resp_valid,
  output logic             resp_fault,
  output logic [XLEN-1:0]  rdata_raw
);

  wb_state_t       state;
  wb_state_t       state_next;
  logic [XLEN-1:0] rdata_q;
  logic            launch;
  logic            fault;

  // A start pulse seen in idle either opens the bus cycle at once or is rejected at once.
  // Both decisions are combinational so that they land in the cycle after acceptance.
  assign fault  = (state == WB_IDLE) & rq.start & acc.misaligned;
  assign launch = (state == WB_IDLE) & rq.start & ~acc.misaligned;

  always_comb begin
    state_next = state;
    unique case (state)
      WB_IDLE: begin
        // An ack in the very first bus cycle skips straight to the response.
        if (launch) begin
          state_next = wb_ack ? WB_RESP : WB_BUS;
        end
      end
      WB_BUS: begin
        if (wb_ack) begin
          state_next = WB_RESP;
        end
      end
      WB_RESP: state_next = WB_IDLE;
      default: state_next = WB_IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= WB_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Read data is captured on the ack edge and shown during WB_RESP.
  always_ff @(posedge CLK) begin
    if (wb_cyc && wb_ack) begin
      rdata_q <= wb_dat_i;
    end
  end

  // Strobe and cycle move together since there are no bursts.
  assign wb_cyc = launch | (state == WB_BUS);
  assign wb_stb = wb_cyc;
  assign wb_we  = wb_cyc & acc.we;

  // The bus is word addressed on byte addresses, so the lane is given by wb_sel alone.
  assign wb_adr   = {acc.addr[XLEN-1:2], 2'b00};
  assign wb_sel   = acc.sel;
  assign wb_dat_o = acc.wdata;

  assign resp_valid = fault | (state == WB_RESP);
  assign resp_fault = fault;

  // A faulting load returns zero instead of a stale bus word.
  assign rdata_raw = fault ? '0 : rdata_q;

endmodule

/* tb/lsu_checker.sv */
// Protocol checker bound to the load/store unit, covering the Wishbone cycle and the response pulse.
`timescale 1ns/1ps

module lsu_checker import rv32_lsu_pkg::*; (
  input logic             CLK,
  input logic             reset,
  input logic             wb_cyc,
  input logic             wb_stb,
  input logic             wb_ack,
  input logic [XLEN-1:0]  wb_adr,
  input logic [SEL_W-1:0] wb_sel,
  input logic             req_ready,
  input logic             resp_valid,
  input wb_state_t        state
);

  // Without bursts, cycle and strobe always move together.
  a_cyc_is_stb: assert property (@(posedge CLK) disable iff (reset) wb_cyc == wb_stb)
    else $error("wb_cyc and wb_stb differ");

  // A strobe that has not been acked stays up with a stable address and select.
  a_stb_held: assert property (@(posedge CLK) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel))
    else $error("wb_stb dropped or changed before ack");

  // Only one request is in flight, so the pipeline is stalled during a bus cycle.
  a_busy_on_bus: assert property (@(posedge CLK) disable iff (reset) wb_cyc |-> !req_ready)
    else $error("req_ready high during a bus cycle");

  // The response is offered for exactly one cycle.
  a_resp_pulse: assert property (@(posedge CLK) disable iff (reset) resp_valid |=> !resp_valid)
    else $error("resp_valid held for two cycles");

  // An acked cycle is released at once and the response follows in the next cycle.
  a_ack_to_resp: assert property (@(posedge CLK) disable iff (reset)
    wb_cyc && wb_ack |=> !wb_cyc && resp_valid && state == WB_RESP)
    else $error("bus cycle not closed into a response after ack");

endmodule

bind lsu_top lsu_checker u_checker (
  .CLK        (CLK),
  .reset      (reset),
  .wb_cyc     (wb_cyc),
  .wb_stb     (wb_stb),
  .wb_ack     (wb_ack),
  .wb_adr     (wb_adr),
  .wb_sel     (wb_sel),
  .req_ready  (req_ready),
  .resp_valid (resp_valid),
  .state      (u_wb_master.state)
);

/* tb/tb_lsu.sv */
// Testbench for the load/store unit with a Wishbone memory model and a reference access model.
`timescale 1ns/1ps

module tb_lsu import rv32_lsu_pkg::*; ();

  logic             CLK;
  logic             reset;
  logic             req_valid;
  mem_op_t          req_op;
  logic [XLEN-1:0]  req_base;
  logic [XLEN-1:0]  req_offset;
  logic [XLEN-1:0]  req_wdata;
  logic             req_ready;
  logic             resp_valid;
  logic             resp_fault;
  logic [XLEN-1:0]  resp_rdata;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [XLEN-1:0]  wb_adr;
  logic [SEL_W-1:0] wb_sel;
  logic [XLEN-1:0]  wb_dat_o;
  logic [XLEN-1:0]  wb_dat_i = '0;
  logic             wb_ack = 1'b0;

  // Slave memory and the shadow copy kept by the reference model.
  logic [XLEN-1:0] mem [256];
  logic [XLEN-1:0] model_mem [256];
  logic            slave_busy = 1'b0;
  int              wait_left = 0;
  int              bus_cycles = 0;
  int              exp_bus_cycles = 0;
  int              resp_count = 0;
  int              checks = 0;
  int              errors = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  integer          seed = 32'h54e64105;

  // Expected responses, in request order.
  logic            exp_fault_q [$];
  logic [XLEN-1:0] exp_rdata_q [$];
  logic [7:0]      exp_idx_q [$];
  logic [XLEN-1:0] exp_word_q [$];

  mem_op_t ops [8] = '{LB, LH, LW, LBU, LHU, SB, SH, SW};

  lsu_top UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Initial memory word, different for every word address.
  function automatic logic [XLEN-1:0] fill_word(input logic [7:0] idx);
    return ({24'd0, idx} + 32'd1) * 32'h9e37_79b9;
  endfunction

  // Expected outcome of one access on the word it touches.
  function automatic void ref_access(
    input  mem_op_t         op,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,
    input  logic [XLEN-1:0] word_in,
    output logic            fault,
    output logic [XLEN-1:0] rdata,
    output logic [XLEN-1:0] word_out
  );
    int              size;
    int              shift;
    logic [XLEN-1:0] mask;
    logic [XLEN-1:0] val;
    case (op)
      LB, LBU, SB: size = 1;
      LH, LHU, SH: size = 2;
      default:     size = 4;
    endcase
    mask     = (size == 4) ? 32'hffff_ffff : ((32'd1 << (8 * size)) - 32'd1);
    shift    = 8 * int'(addr[1:0]);
    // Natural alignment: the byte offset must be a multiple of the size.
    fault    = (int'(addr[1:0]) % size) != 0;
    rdata    = '0;
    word_out = word_in;
    if (!fault) begin
      if (op == SB || op == SH || op == SW) begin
        word_out = (word_in & ~(mask << shift)) | ((wdata & mask) << shift);
      end else begin
        val = (word_in >> shift) & mask;
        if (op == LB && val[7]) val = val | 32'hffff_ff00;
        if (op == LH && val[15]) val = val | 32'hffff_0000;
        rdata = val;
      end
    end
  endfunction

  // Wishbone slave. It waits 0 to 3 extra cycles, then acks for one cycle.
  always @(posedge CLK) begin : wb_slave
    logic [XLEN-1:0] lane_mask;
    logic [8:0]      k;
    lane_mask = {{8{wb_sel[3]}}, {8{wb_sel[2]}}, {8{wb_sel[1]}}, {8{wb_sel[0]}}};
    if (reset) begin
      wb_ack <= 1'b0;
      slave_busy = 1'b0;
      for (k = 0; k < 256; k++) mem[k[7:0]] <= fill_word(k[7:0]);
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
      slave_busy = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!slave_busy) begin
        slave_busy = 1'b1;
        wait_left = $random(seed) & 3;
      end
      if (wait_left == 0) begin
        // Only the selected lanes of the word are written.
        wb_ack     <= 1'b1;
        wb_dat_i   <= mem[wb_adr[9:2]];
        bus_cycles <= bus_cycles + 1;
        if (wb_we) begin
          mem[wb_adr[9:2]] <= (mem[wb_adr[9:2]] & ~lane_mask) | (wb_dat_o & lane_mask);
        end
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // Response comparison, sampled mid-cycle while the response is stable.
  always @(negedge CLK) begin : compare_resp
    logic            exp_fault;
    logic [XLEN-1:0] exp_rdata;
    logic [7:0]      exp_idx;
    logic [XLEN-1:0] exp_word;
    if (!reset && resp_valid) begin
      assert (exp_fault_q.size() > 0) else begin
        $display("response at %0t arrived with no request outstanding", $time);
        errors++;
      end
      if (exp_fault_q.size() > 0) begin
        exp_fault = exp_fault_q.pop_front();
        exp_rdata = exp_rdata_q.pop_front();
        exp_idx   = exp_idx_q.pop_front();
        exp_word  = exp_word_q.pop_front();
        // A fault must never reach the bus.
        if (!exp_fault) exp_bus_cycles++;
        checks += 4;
        assert (resp_fault === exp_fault) else begin
          $display("error at %0t: resp_fault is %0b, expected %0b", $time, resp_fault, exp_fault);
          errors++;
        end
        assert (resp_rdata === exp_rdata) else begin
          $display("error at %0t: resp_rdata is %h, expected %h", $time, resp_rdata, exp_rdata);
          errors++;
        end
        assert (bus_cycles == exp_bus_cycles) else begin
          $display("error at %0t: bus_cycles is %0d, expected %0d", $time, bus_cycles,
                   exp_bus_cycles);
          errors++;
        end
        assert (mem[exp_idx] === exp_word) else begin
          $display("error at %0t: mem[%0d] is %h, expected %h", $time, exp_idx, mem[exp_idx],
                   exp_word);
          errors++;
        end
      end
      resp_count++;
    end
  end

  task automatic abort_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("Verification failed");
    $finish;
  endtask

  // Predicts one access, offers it to the DUT and waits for its response.
  task automatic issue_op(input mem_op_t op, input logic [XLEN-1:0] base,
                          input logic [XLEN-1:0] offset, input logic [XLEN-1:0] wdata);
    logic [XLEN-1:0] addr;
    logic [7:0]      idx;
    logic            exp_fault;
    logic [XLEN-1:0] exp_rdata;
    logic [XLEN-1:0] exp_word;
    logic            accepted;
    int              target;
    int              waited;
    addr = base + offset;
    idx  = addr[9:2];
    ref_access(op, addr, wdata, model_mem[idx], exp_fault, exp_rdata, exp_word);
    model_mem[idx] = exp_word;
    exp_fault_q.push_back(exp_fault);
    exp_rdata_q.push_back(exp_rdata);
    exp_idx_q.push_back(idx);
    exp_word_q.push_back(exp_word);
    target = resp_count + 1;
    @(posedge CLK);
    req_valid  <= 1'b1;
    req_op     <= op;
    req_base   <= base;
    req_offset <= offset;
    req_wdata  <= wdata;
    accepted = 1'b0;
    waited   = 0;
    while (!accepted && waited < 20) begin
      @(posedge CLK);
      accepted = req_ready;
      waited++;
    end
    req_valid <= 1'b0;
    if (!accepted) abort_run("request was never accepted");
    waited = 0;
    while (resp_count < target && waited < 40) begin
      @(posedge CLK);
      waited++;
    end
    if (resp_count < target) abort_run("no response arrived for the request");
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin : stimulus
    logic [XLEN-1:0] off;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] pick;
    logic [8:0]      k;
    int              err0;
    int              n;
    req_valid  = 1'b0;
    req_op     = LW;
    req_base   = '0;
    req_offset = '0;
    req_wdata  = '0;
    reset      = 1'b1;
    for (k = 0; k < 256; k++) model_mem[k[7:0]] = fill_word(k[7:0]);
    repeat (16) @(posedge CLK);
    reset <= 1'b0;

    // Word store and reload, with a negative offset.
    err0 = errors;
    for (n = 0; n < 4; n++) begin
      word = $random(seed);
      issue_op(SW, 32'h1000 + (32'(n) << 6), 32'hffff_fffc, word);
      issue_op(LW, 32'h1000 + (32'(n) << 6), 32'hffff_fffc, 32'h0);
    end
    finish_test("store word and load word", err0);

    // Each narrow store must leave the other lanes alone.
    err0 = errors;
    for (off = 0; off < 4; off++) begin
      issue_op(SB, 32'h300, off, $random(seed));
      issue_op(LW, 32'h300, 32'h0, 32'h0);
    end
    for (off = 0; off < 4; off += 2) begin
      issue_op(SH, 32'h300, off, $random(seed));
      issue_op(LW, 32'h300, 32'h0, 32'h0);
    end
    finish_test("byte and half stores", err0);

    // One word with negative lanes, one with positive lanes.
    err0 = errors;
    for (n = 0; n < 2; n++) begin
      issue_op(SW, 32'h400, 32'h0, (n == 0) ? 32'h80ff_f580 : 32'h7f01_7f7e);
      for (off = 0; off < 4; off++) begin
        issue_op(LB, 32'h400, off, 32'h0);
        issue_op(LBU, 32'h400, off, 32'h0);
      end
      for (off = 0; off < 4; off += 2) begin
        issue_op(LH, 32'h400, off, 32'h0);
        issue_op(LHU, 32'h400, off, 32'h0);
      end
    end
    finish_test("narrow load extension", err0);

    err0 = errors;
    for (off = 1; off < 4; off++) issue_op(LW, 32'h500, off, 32'h0);
    issue_op(LH, 32'h500, 32'h1, 32'h0);
    issue_op(LH, 32'h500, 32'h3, 32'h0);
    issue_op(SW, 32'h500, 32'h2, 32'hdead_beef);
    issue_op(SH, 32'h500, 32'h1, 32'hdead_beef);
    issue_op(LW, 32'h500, 32'h0, 32'h0);
    finish_test("misaligned faults", err0);

    // Full-range base and offset, so many sums wrap past 32 bits.
    err0 = errors;
    for (n = 0; n < 200; n++) begin
      pick = $random(seed);
      issue_op(ops[pick[2:0]], $random(seed), $random(seed), $random(seed));
    end
    finish_test("random operations", err0);

    repeat (4) @(posedge CLK);
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d", tests_run,
             tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
